/* ptw_sv39.f */
verilog/ptw_sv39_pkg.sv
verilog/ptw_pte_check.sv
verilog/ptw_walk_ctx.sv
verilog/ptw_walk_fsm.sv
verilog/ptw_sv39.sv
verif/ptw_sv39_assertions.sv
verif/ptw_sv39_checker.sv
verif/tb_ptw_sv39.sv

/* verif/ptw_sv39_assertions.sv */
/*
 * Bound checks on the read request handshake and the output pulses
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_sv39_assertions import ptw_sv39_pkg::*; (
    input logic       clk_i,
    input logic       rst_ni,
    input mem_req_t   mem_req_o,
    input mem_rsp_t   mem_rsp_i,
    input logic       busy_o,
    input logic       update_valid_o,
    input ptw_fault_t fault_o
);

    int unsigned fail_count = 0;

    // Request and address held until accepted
    ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.ar_valid && !mem_rsp_i.ar_ready
        |=> mem_req_o.ar_valid && $stable(mem_req_o.ar_addr))
    else begin
        $error("ar_valid dropped or ar_addr changed before ar_ready");
        fail_count++;
    end

    no_update_with_fault: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(update_valid_o && fault_o.valid))
    else begin
        $error("update_valid_o and fault_o.valid high in the same cycle");
        fail_count++;
    end

    // Single-cycle strobes
    update_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        update_valid_o |=> !update_valid_o)
    else begin
        $error("update_valid_o high for more than one cycle");
        fail_count++;
    end

    fault_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        fault_o.valid |=> !fault_o.valid)
    else begin
        $error("fault_o.valid high for more than one cycle");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> !mem_req_o.ar_valid && !mem_req_o.r_ready && !busy_o
                    && !update_valid_o && !fault_o.valid)
    else begin
        $error("control output high during reset");
        fail_count++;
    end

endmodule

bind ptw_sv39 ptw_sv39_assertions i_ptw_sv39_assertions (.*);

`default_nettype wire

/* verif/ptw_sv39_checker.sv */
/*
 * Response checker: expected walk queue, per-test lines and counts
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_sv39_checker import ptw_sv39_pkg::*; (
    input logic          clk_i,
    input logic          rst_ni,
    input logic          update_valid_i,
    input iotlb_update_t update_i,
    input ptw_fault_t    fault_i
);

    // Expected results in walk order
    string                name_q[$];
    bit                   fault_q[$];
    iotlb_update_t        upd_q[$];
    logic [CAUSE_LEN-1:0] cause_q[$];
    int unsigned          test_count  = 0;
    int unsigned          error_count = 0;

    task automatic expect_walk(input string name, input bit is_fault,
                               input iotlb_update_t upd, input logic [CAUSE_LEN-1:0] cause);
        name_q.push_back(name);
        fault_q.push_back(is_fault);
        upd_q.push_back(upd);
        cause_q.push_back(cause);
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR %s", msg);
        error_count++;
    endtask

    task automatic drop_front();
        void'(name_q.pop_front());
        void'(fault_q.pop_front());
        void'(upd_q.pop_front());
        void'(cause_q.pop_front());
        test_count++;
    endtask

    // Walk over with its entry still queued
    task automatic check_drained(input string name);
        if (name_q.size() != 0) begin
            note_failure({name, ": walk ended with no update and no fault"});
            drop_front();
        end
    endtask

    task automatic print_counts();
        $display("Tests run: %0d, errors: %0d", test_count, error_count);
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk_i) begin : compare
        string exp_s;
        string act_s;
        bit    ok;
        if (rst_ni && (update_valid_i || fault_i.valid)) begin
            if (name_q.size() == 0) begin
                note_failure("update or fault seen with no walk pending");
            end else begin
                ok = fault_q[0] ? (fault_i.valid && !update_valid_i
                                   && fault_i.cause === cause_q[0])
                                : (update_valid_i && !fault_i.valid
                                   && update_i === upd_q[0]);
                exp_s = fault_q[0] ? $sformatf("cause %0d", cause_q[0])
                                   : $sformatf("update %h", upd_q[0]);
                act_s = fault_i.valid ? $sformatf("cause %0d", fault_i.cause)
                                      : $sformatf("update %h", update_i);
                if (ok) begin
                    $display("ok       %s", name_q[0]);
                end else begin
                    $display("MISMATCH %s expected %s actual %s", name_q[0], exp_s, act_s);
                    error_count++;
                end
                drop_front();
            end
        end
    end

endmodule

`default_nettype wire

/* verif/tb_ptw_sv39.sv */
/*
 * Walker testbench: clock, reset, page-table memory model with random back-pressure
 * Directed walks, software reference walk and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ptw_sv39 import ptw_sv39_pkg::*; ();

    localparam int unsigned     NUM_TESTS       = 26;
    localparam int unsigned     CYCLES_PER_TEST = 200;
    localparam logic [PPNW-1:0] ROOT_PPN        = 44'h100;
    // PTE flag byte from D down to V
    localparam logic [7:0]      PTR             = 8'b0000_0001;
    localparam logic [7:0]      LEAF            = 8'b1100_1111;

    logic               clk_i;
    logic               rst_ni;
    logic               init_ptw;
    logic               is_store;
    logic [XLEN-1:0]    req_iova;
    logic [PSCID_W-1:0] pscid;
    logic [PPNW-1:0]    satp_ppn;
    mem_req_t           mem_req;
    mem_rsp_t           mem_rsp;
    logic               busy;
    logic               update_valid;
    iotlb_update_t      update;
    ptw_fault_t         fault;
    int unsigned        test_idx;

    // Page tables and addresses that answer with a bus error
    pte_t mem [logic [PLEN-1:0]];
    bit   err_map [logic [PLEN-1:0]];

    ptw_sv39 i_ptw_sv39 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_ptw_i     (init_ptw),
        .is_store_i     (is_store),
        .req_iova_i     (req_iova),
        .pscid_i        (pscid),
        .satp_ppn_i     (satp_ppn),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .busy_o         (busy),
        .update_valid_o (update_valid),
        .update_o       (update),
        .fault_o        (fault)
    );

    ptw_sv39_checker i_ptw_sv39_checker (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .update_valid_i (update_valid),
        .update_i       (update),
        .fault_i        (fault)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Ends a hung run
    initial begin : watchdog
        repeat (16 + CYCLES_PER_TEST * NUM_TESTS) @(posedge clk_i);
        $display("Watchdog expired before all walks completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Memory model with one outstanding read
    initial begin : mem_model
        logic            ar_hs;
        logic            r_hs;
        logic            pending;
        int unsigned     delay;
        logic [PLEN-1:0] addr;
        void'($urandom(93178));
        mem_rsp = '0;
        pending = 1'b0;
        delay   = 0;
        addr    = '0;
        forever begin
            // Handshakes seen at the falling edge match the next rising edge
            @(negedge clk_i);
            ar_hs = mem_req.ar_valid && mem_rsp.ar_ready;
            r_hs  = mem_rsp.r_valid && mem_req.r_ready;
            if (ar_hs) begin
                addr    = mem_req.ar_addr;
                pending = 1'b1;
                delay   = $urandom_range(4, 0);
            end
            @(posedge clk_i);
            #2;
            if (r_hs) begin
                mem_rsp.r_valid = 1'b0;
                mem_rsp.r_err   = 1'b0;
            end
            if (pending && delay == 0) begin
                mem_rsp.r_valid = 1'b1;
                mem_rsp.r_data  = mem.exists(addr) ? mem[addr] : '0;
                mem_rsp.r_err   = err_map.exists(addr);
                pending         = 1'b0;
            end else if (pending) begin
                delay--;
            end
            mem_rsp.ar_ready = $urandom_range(1, 0);
        end
    end

    function automatic pte_t mk_pte(input logic [PPNW-1:0] ppn, input logic [7:0] flags);
        return {10'h0, ppn, 2'b00, flags};
    endfunction

    function automatic logic [PLEN-1:0] pte_addr(input logic [PPNW-1:0] base,
                                                 input logic [LVL_IDX_W-1:0] idx);
        return {base, idx, 3'b000};
    endfunction

    function automatic void set_pte(input logic [PPNW-1:0] base,
                                    input logic [LVL_IDX_W-1:0] idx, input pte_t p);
        mem[pte_addr(base, idx)] = p;
    endfunction

    // IOVA from the three VPN segments
    function automatic logic [XLEN-1:0] va(input logic [LVL_IDX_W-1:0] vpn2,
                                          input logic [LVL_IDX_W-1:0] vpn1,
                                          input logic [LVL_IDX_W-1:0] vpn0);
        return {25'h0, vpn2, vpn1, vpn0, 12'habc};
    endfunction

    // Software walk over the same tables that returns 1 on a fault
    function automatic bit ref_walk(input logic [XLEN-1:0] iova, input logic [PSCID_W-1:0] id,
                                    input logic st, output iotlb_update_t upd,
                                    output logic [CAUSE_LEN-1:0] cause);
        logic [PPNW-1:0] base;
        logic [PLEN-1:0] addr;
        pte_t            p;
        logic            g_acc;
        logic            bad;
        upd   = '0;
        cause = st ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
        base  = ROOT_PPN;
        g_acc = 1'b0;
        for (int i = 0; i < 3; i++) begin
            addr = {base, iova[PAGE_OFFSET+(2-i)*LVL_IDX_W +: LVL_IDX_W], 3'b000};
            if (err_map.exists(addr)) begin
                cause = PT_DATA_CORRUPTION;
                return 1'b1;
            end
            p = mem.exists(addr) ? mem[addr] : '0;
            if (!p.v || (p.w && !p.r) || (p.reserved != 0)) begin
                return 1'b1;
            end
            if (!(p.r || p.x)) begin
                // A pointer carries no A D U and needs a table below it
                if (p.a || p.d || p.u || i == 2) begin
                    return 1'b1;
                end
                g_acc = g_acc | p.g;
                base  = p.ppn;
            end else begin
                bad = !p.a || !p.r || (st && !p.d)
                      || (i == 0 && p.ppn[2*LVL_IDX_W-1:0] != 0)
                      || (i == 1 && p.ppn[LVL_IDX_W-1:0] != 0);
                if (bad) begin
                    return 1'b1;
                end
                upd.vpn       = iova[VLEN-1:PAGE_OFFSET];
                upd.pscid     = id;
                upd.is_1g     = (i == 0);
                upd.is_2m     = (i == 1);
                upd.content   = p;
                upd.content.g = p.g | g_acc;
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // One walk with the trigger held high afterwards to catch a second start
    task automatic run_walk(input string name, input logic [XLEN-1:0] iova, input logic st);
        iotlb_update_t        exp_upd;
        logic [CAUSE_LEN-1:0] exp_cause;
        logic [PSCID_W-1:0]   id;
        bit                   exp_fault;
        test_idx++;
        id        = 20'h5A000 + test_idx[PSCID_W-1:0];
        exp_fault = ref_walk(iova, id, st, exp_upd, exp_cause);
        i_ptw_sv39_checker.expect_walk(name, exp_fault, exp_upd, exp_cause);
        @(posedge clk_i);
        #2;
        init_ptw = 1'b1;
        is_store = st;
        req_iova = iova;
        pscid    = id;
        satp_ppn = ROOT_PPN;
        @(posedge clk_i);
        @(negedge clk_i);
        if (!busy) begin
            i_ptw_sv39_checker.note_failure({name, ": walk did not start"});
        end
        while (busy) @(negedge clk_i);
        repeat (4) begin
            @(negedge clk_i);
            if (busy) begin
                i_ptw_sv39_checker.note_failure({name, ": held trigger started a second walk"});
            end
        end
        i_ptw_sv39_checker.check_drained(name);
        @(posedge clk_i);
        #2;
        init_ptw = 1'b0;
    endtask

    initial begin : stimulus
        pte_t p;
        init_ptw = 1'b0;
        is_store = 1'b0;
        req_iova = '0;
        pscid    = '0;
        satp_ppn = '0;
        test_idx = 0;
        rst_ni   = 1'b0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // 4 KiB pages where the second root entry shares the tree with G set
        set_pte(ROOT_PPN, 1, mk_pte(44'h201, PTR));
        set_pte(ROOT_PPN, 2, mk_pte(44'h201, 8'b0010_0001));
        set_pte(44'h201, 5, mk_pte(44'h301, PTR));
        set_pte(44'h301, 7, mk_pte(44'h12345, LEAF));
        run_walk("4k_load", va(1, 5, 7), 1'b0);
        run_walk("4k_store", va(1, 5, 7), 1'b1);
        run_walk("4k_global", va(2, 5, 7), 1'b0);

        // Aligned and misaligned superpages
        set_pte(ROOT_PPN, 3, mk_pte(44'h203, PTR));
        set_pte(44'h203, 4, mk_pte(44'h400, LEAF));
        set_pte(44'h203, 6, mk_pte(44'h401, LEAF));
        set_pte(ROOT_PPN, 4, mk_pte(44'h40000, LEAF));
        set_pte(ROOT_PPN, 5, mk_pte(44'h40200, LEAF));
        run_walk("2m_load", va(3, 4, 0), 1'b0);
        run_walk("2m_store", va(3, 4, 0), 1'b1);
        run_walk("2m_misaligned_store", va(3, 6, 0), 1'b1);
        run_walk("1g_load", va(4, 0, 0), 1'b0);
        run_walk("1g_misaligned_load", va(5, 0, 0), 1'b0);

        // One entry per PTE fault rule
        set_pte(44'h301, 0, mk_pte(44'h500, 8'b1100_0101));
        p          = mk_pte(44'h500, 8'b1100_0011);
        p.reserved = 10'h200;
        set_pte(44'h301, 1, p);
        set_pte(44'h201, 1, mk_pte(44'h302, 8'b0001_0001));
        set_pte(44'h201, 2, mk_pte(44'h302, 8'b1000_0001));
        set_pte(44'h201, 4, mk_pte(44'h302, 8'b0100_0001));
        set_pte(44'h301, 2, mk_pte(44'h303, PTR));
        set_pte(44'h301, 3, mk_pte(44'h500, 8'b1000_0011));
        set_pte(44'h301, 4, mk_pte(44'h500, 8'b0100_0011));
        // Execute-only leaf
        set_pte(44'h301, 5, mk_pte(44'h500, 8'b1100_1001));
        run_walk("invalid_load", va(6, 0, 0), 1'b0);
        run_walk("w_no_r_store", va(1, 5, 0), 1'b1);
        run_walk("reserved_load", va(1, 5, 1), 1'b0);
        run_walk("ptr_user_store", va(1, 1, 0), 1'b1);
        run_walk("ptr_dirty_load", va(1, 2, 0), 1'b0);
        run_walk("ptr_accessed_store", va(1, 4, 0), 1'b1);
        run_walk("ptr_at_lvl3_load", va(1, 5, 2), 1'b0);
        run_walk("a_clear_store", va(1, 5, 3), 1'b1);
        run_walk("d_clear_store", va(1, 5, 4), 1'b1);
        run_walk("d_clear_load", va(1, 5, 4), 1'b0);
        run_walk("r_clear_load", va(1, 5, 5), 1'b0);

        // Bus errors at each level
        err_map[pte_addr(ROOT_PPN, 7)] = 1'b1;
        err_map[pte_addr(44'h201, 3)]  = 1'b1;
        err_map[pte_addr(44'h301, 8)]  = 1'b1;
        run_walk("err_lvl1", va(7, 0, 0), 1'b0);
        run_walk("err_lvl2", va(1, 3, 0), 1'b1);
        run_walk("err_lvl3", va(1, 5, 8), 1'b0);

        // Back-to-back walks under random back-pressure
        repeat (4) run_walk("4k_repeat", va(2, 5, 7), 1'b1);

        i_ptw_sv39_checker.print_counts();
        if (i_ptw_sv39_checker.error_count == 0
            && i_ptw_sv39_checker.test_count == NUM_TESTS
            && i_ptw_sv39.i_ptw_sv39_assertions.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/ptw_pte_check.sv */
/*
 * Combinational Sv39 PTE classification
 * Leaf or pointer decision and page-fault checks
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_pte_check import ptw_sv39_pkg::*; (
    input  pte_t     pte_i,
    input  ptw_lvl_e lvl_i,
    input  logic     is_store_i,
    output logic     is_leaf_o,
    output logic     pte_fault_o
);

    logic invalid;
    logic misaligned;
    logic leaf_fault;
    logic ptr_fault;

    // R or X marks a leaf, anything else points to the next table
    assign is_leaf_o = pte_i.r | pte_i.x;

    // Not valid, write without read, or reserved bits set
    assign invalid = !pte_i.v || (pte_i.w && !pte_i.r) || (|pte_i.reserved);

    // Superpage PPN must be aligned to its page size
    always_comb begin
        misaligned = 1'b0;
        case (lvl_i)
            // 1 GiB leaf, low two PPN segments clear
            LVL1: misaligned = |pte_i.ppn[2*LVL_IDX_W-1:0];
            // 2 MiB leaf
            LVL2: misaligned = |pte_i.ppn[LVL_IDX_W-1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Leaf checks
    // A must be set, R must be set, stores need D
    assign leaf_fault = misaligned
                        || !pte_i.a
                        || !pte_i.r
                        || (is_store_i && !pte_i.d);

    // Pointer checks
    // A, D and U are reserved on non-leaf entries
    // No table below level 3
    assign ptr_fault = pte_i.a
                       || pte_i.d
                       || pte_i.u
                       || (lvl_i == LVL3);

    assign pte_fault_o = invalid || (is_leaf_o ? leaf_fault : ptr_fault);

endmodule

`default_nettype wire

/* verilog/ptw_sv39.sv */
/*
 * Sv39 IOMMU page table walker top level
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_sv39 import ptw_sv39_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                init_ptw_i,
    input  logic                is_store_i,
    input  logic [XLEN-1:0]     req_iova_i,
    input  logic [PSCID_W-1:0]  pscid_i,
    input  logic [PPNW-1:0]     satp_ppn_i,
    output mem_req_t            mem_req_o,
    input  mem_rsp_t            mem_rsp_i,
    output logic                busy_o,
    output logic                update_valid_o,
    output iotlb_update_t       update_o,
    output ptw_fault_t          fault_o
);

    logic            start;
    logic            pte_accept;
    ptw_lvl_e        lvl;
    logic [VLEN-1:0] iova;
    logic            is_store_q;
    logic            is_leaf;
    logic            pte_fault;
    pte_t            rsp_pte;

    // Read data seen as a PTE
    assign rsp_pte = pte_t'(mem_rsp_i.r_data);

    ptw_walk_fsm i_ptw_walk_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_ptw_i     (init_ptw_i),
        .satp_ppn_i     (satp_ppn_i),
        .req_iova_i     (req_iova_i),
        .iova_i         (iova),
        .mem_rsp_i      (mem_rsp_i),
        .is_leaf_i      (is_leaf),
        .pte_fault_i    (pte_fault),
        .is_store_i     (is_store_q),
        .mem_req_o      (mem_req_o),
        .busy_o         (busy_o),
        .start_o        (start),
        .pte_accept_o   (pte_accept),
        .lvl_o          (lvl),
        .update_valid_o (update_valid_o),
        .fault_o        (fault_o)
    );

    ptw_pte_check i_ptw_pte_check (
        .pte_i       (rsp_pte),
        .lvl_i       (lvl),
        .is_store_i  (is_store_q),
        .is_leaf_o   (is_leaf),
        .pte_fault_o (pte_fault)
    );

    ptw_walk_ctx i_ptw_walk_ctx (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .req_iova_i   (req_iova_i),
        .pscid_i      (pscid_i),
        .is_store_i   (is_store_i),
        .pte_i        (rsp_pte),
        .lvl_i        (lvl),
        .pte_accept_i (pte_accept),
        .iova_o       (iova),
        .is_store_o   (is_store_q),
        .update_o     (update_o)
    );

endmodule

`default_nettype wire

/* verilog/ptw_sv39_pkg.sv */
/*
 * Sv39 walker widths, cause codes and walk levels
 * PTE layout, read channel structs, IOTLB update and fault records
 */
`default_nettype none

package ptw_sv39_pkg;

    // Address and page number widths
    localparam int unsigned PLEN        = 56;
    localparam int unsigned PPNW        = 44;
    localparam int unsigned VLEN        = 39;
    localparam int unsigned VPNW        = 27;
    localparam int unsigned XLEN        = 64;
    localparam int unsigned PAGE_OFFSET = 12;
    // One VPN segment per level
    localparam int unsigned LVL_IDX_W   = 9;

    // Fault reporting
    localparam int unsigned CAUSE_LEN   = 12;
    localparam int unsigned PSCID_W     = 20;

    localparam logic [CAUSE_LEN-1:0] LOAD_PAGE_FAULT    = 12'd13;
    localparam logic [CAUSE_LEN-1:0] STORE_PAGE_FAULT   = 12'd15;
    // Bus error while fetching a PTE
    localparam logic [CAUSE_LEN-1:0] PT_DATA_CORRUPTION = 12'd274;

    // Walk level, LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    // Sv39 page table entry, MSB first
    typedef struct packed {
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // Read request driven by the walker
    typedef struct packed {
        logic            ar_valid;
        logic [PLEN-1:0] ar_addr;
        logic            r_ready;
    } mem_req_t;

    // Read response returned by memory
    typedef struct packed {
        logic            ar_ready;
        logic            r_valid;
        logic [63:0]     r_data;
        // Set together with r_valid on a bus error
        logic            r_err;
    } mem_rsp_t;

    // IOTLB fill record
    typedef struct packed {
        logic [VPNW-1:0]    vpn;
        logic [PSCID_W-1:0] pscid;
        logic               is_2m;
        logic               is_1g;
        // Leaf PTE with accumulated G bit
        pte_t               content;
    } iotlb_update_t;

    // Fault report, valid for one cycle
    typedef struct packed {
        logic                 valid;
        logic [CAUSE_LEN-1:0] cause;
    } ptw_fault_t;

endpackage

`default_nettype wire

/* verilog/ptw_walk_ctx.sv */
/*
 * Walk context registers: IOVA, PSCID, store flag and global bit
 * Composition of the IOTLB update record
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_ctx import ptw_sv39_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                start_i,
    input  logic [XLEN-1:0]     req_iova_i,
    input  logic [PSCID_W-1:0]  pscid_i,
    input  logic                is_store_i,
    input  pte_t                pte_i,
    input  ptw_lvl_e            lvl_i,
    input  logic                pte_accept_i,
    output logic [VLEN-1:0]     iova_o,
    output logic                is_store_o,
    output iotlb_update_t       update_o
);

    logic [VLEN-1:0]    iova_q;
    logic [PSCID_W-1:0] pscid_q;
    logic               is_store_q;
    logic               global_q;

    // Control state
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            is_store_q <= 1'b0;
            global_q   <= 1'b0;
        end else if (start_i) begin
            is_store_q <= is_store_i;
            // New walk, forget G from the previous one
            global_q   <= 1'b0;
        end else if (pte_accept_i && pte_i.g) begin
            global_q   <= 1'b1;
        end
    end

    // Request tags, captured once per walk
    always_ff @(posedge clk_i) begin
        if (start_i) begin
            // Only the Sv39 part of the IOVA is kept
            iova_q  <= req_iova_i[VLEN-1:0];
            pscid_q <= pscid_i;
        end
    end

    assign iova_o     = iova_q;
    assign is_store_o = is_store_q;

    // Record follows the PTE on the read bus
    // Only sampled by the IOTLB while update_valid_o is high
    always_comb begin
        update_o           = '0;
        update_o.vpn       = iova_q[VLEN-1:PAGE_OFFSET];
        update_o.pscid     = pscid_q;
        update_o.is_2m     = (lvl_i == LVL2);
        update_o.is_1g     = (lvl_i == LVL1);
        update_o.content   = pte_i;
        // G from any level applies to the whole mapping
        update_o.content.g = pte_i.g | global_q;
    end

endmodule

`default_nettype wire

/* verilog/ptw_walk_fsm.sv */
/*
 * Sv39 walk FSM with trigger edge detection and level counter
 * Drives the read channel, the update strobe and the fault report
 */
`timescale 1ns/1ps
`default_nettype none

module ptw_walk_fsm import ptw_sv39_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                init_ptw_i,
    input  logic [PPNW-1:0]     satp_ppn_i,
    input  logic [XLEN-1:0]     req_iova_i,
    input  logic [VLEN-1:0]     iova_i,
    input  mem_rsp_t            mem_rsp_i,
    input  logic                is_leaf_i,
    input  logic                pte_fault_i,
    input  logic                is_store_i,
    output mem_req_t            mem_req_o,
    output logic                busy_o,
    output logic                start_o,
    output logic                pte_accept_o,
    output ptw_lvl_e            lvl_o,
    output logic                update_valid_o,
    output ptw_fault_t          fault_o
);

    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } state_e;

    state_e               state_q, state_n;
    ptw_lvl_e             lvl_q, lvl_n;
    logic [PLEN-1:0]      pptr_q, pptr_n;
    logic                 corrupt_q, corrupt_n;
    // Last sampled trigger level
    logic                 trig_q;
    pte_t                 rsp_pte;
    logic [LVL_IDX_W-1:0] root_vpn_seg;
    logic [LVL_IDX_W-1:0] next_vpn_seg;

    assign rsp_pte = pte_t'(mem_rsp_i.r_data);

    // VPN[2] indexes the root table
    assign root_vpn_seg = req_iova_i[PAGE_OFFSET+2*LVL_IDX_W +: LVL_IDX_W];

    // Segment for the table below the current level
    assign next_vpn_seg = (lvl_q == LVL1) ? iova_i[PAGE_OFFSET+LVL_IDX_W +: LVL_IDX_W]
                                          : iova_i[PAGE_OFFSET +: LVL_IDX_W];

    assign busy_o = (state_q != IDLE);
    assign lvl_o  = lvl_q;

    always_comb begin
        state_n            = state_q;
        lvl_n              = lvl_q;
        pptr_n             = pptr_q;
        corrupt_n          = corrupt_q;
        mem_req_o.ar_valid = 1'b0;
        mem_req_o.ar_addr  = pptr_q;
        mem_req_o.r_ready  = 1'b0;
        start_o            = 1'b0;
        pte_accept_o       = 1'b0;
        update_valid_o     = 1'b0;
        fault_o            = '0;

        case (state_q)
            IDLE: begin
                // Start only on a rising trigger
                if (init_ptw_i && !trig_q) begin
                    start_o   = 1'b1;
                    lvl_n     = LVL1;
                    corrupt_n = 1'b0;
                    pptr_n    = {satp_ppn_i, root_vpn_seg, 3'b000};
                    state_n   = MEM_ACCESS;
                end
            end

            MEM_ACCESS: begin
                // Address held stable until accepted
                mem_req_o.ar_valid = 1'b1;
                if (mem_rsp_i.ar_ready) begin
                    state_n = PROC_PTE;
                end
            end

            PROC_PTE: begin
                if (mem_rsp_i.r_valid) begin
                    mem_req_o.r_ready = 1'b1;
                    pte_accept_o      = 1'b1;
                    if (mem_rsp_i.r_err) begin
                        // Bus error wins over any PTE content
                        corrupt_n = 1'b1;
                        state_n   = ERROR;
                    end else if (pte_fault_i) begin
                        state_n = ERROR;
                    end else if (is_leaf_i) begin
                        // Record valid in the same cycle as the beat
                        update_valid_o = 1'b1;
                        state_n        = IDLE;
                    end else begin
                        // Pointer, descend one level
                        lvl_n   = (lvl_q == LVL1) ? LVL2 : LVL3;
                        pptr_n  = {rsp_pte.ppn, next_vpn_seg, 3'b000};
                        state_n = MEM_ACCESS;
                    end
                end
            end

            ERROR: begin
                fault_o.valid = 1'b1;
                if (corrupt_q) begin
                    fault_o.cause = PT_DATA_CORRUPTION;
                end else begin
                    fault_o.cause = is_store_i ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
                end
                state_n = IDLE;
            end

            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= IDLE;
            lvl_q     <= LVL1;
            corrupt_q <= 1'b0;
            trig_q    <= 1'b0;
        end else begin
            state_q   <= state_n;
            lvl_q     <= lvl_n;
            corrupt_q <= corrupt_n;
            // Held-high trigger never restarts a walk
            trig_q    <= init_ptw_i;
        end
    end

    // Next PTE address
    always_ff @(posedge clk_i) begin
        pptr_q <= pptr_n;
    end

endmodule

`default_nettype wire
